// File: program.hex
// one 128-bit cache line per row with word 3 leftmost
a000000ca0000008a0000004a0000000
a001001ca0010018a0010014a0010010
a002002ca0020028a0020024a0020020
a003003ca0030038a0030034a0030030
a004004ca0040048a0040044a0040040
a005005ca0050058a0050054a0050050
a006006ca0060068a0060064a0060060
a007007ca0070078a0070074a0070070
a008008ca0080088a0080084a0080080
a009009ca0090098a0090094a0090090
a00a00aca00a00a8a00a00a4a00a00a0
a00b00bca00b00b8a00b00b4a00b00b0
a00c00cca00c00c8a00c00c4a00c00c0
a00d00dca00d00d8a00d00d4a00d00d0
a00e00eca00e00e8a00e00e4a00e00e0
a00f00fca00f00f8a00f00f4a00f00f0
a010010ca0100108a0100104a0100100
a011011ca0110118a0110114a0110110
a012012ca0120128a0120124a0120120
a013013ca0130138a0130134a0130130
a014014ca0140148a0140144a0140140
a015015ca0150158a0150154a0150150
a016016ca0160168a0160164a0160160
a017017ca0170178a0170174a0170170
a018018ca0180188a0180184a0180180
a019019ca0190198a0190194a0190190
a01a01aca01a01a8a01a01a4a01a01a0
a01b01bca01b01b8a01b01b4a01b01b0
a01c01cca01c01c8a01c01c4a01c01c0
a01d01dca01d01d8a01d01d4a01d01d0
a01e01eca01e01e8a01e01e4a01e01e0
a01f01fca01f01f8a01f01f4a01f01f0
a020020ca0200208a0200204a0200200
a021021ca0210218a0210214a0210210
a022022ca0220228a0220224a0220220
a023023ca0230238a0230234a0230230
a024024ca0240248a0240244a0240240
a025025ca0250258a0250254a0250250
a026026ca0260268a0260264a0260260
a027027ca0270278a0270274a0270270
a028028ca0280288a0280284a0280280
a029029ca0290298a0290294a0290290
a02a02aca02a02a8a02a02a4a02a02a0
a02b02bca02b02b8a02b02b4a02b02b0
a02c02cca02c02c8a02c02c4a02c02c0
a02d02dca02d02d8a02d02d4a02d02d0
a02e02eca02e02e8a02e02e4a02e02e0
a02f02fca02f02f8a02f02f4a02f02f0
a030030ca0300308a0300304a0300300
a031031ca0310318a0310314a0310310
a032032ca0320328a0320324a0320320
a033033ca0330338a0330334a0330330
a034034ca0340348a0340344a0340340
a035035ca0350358a0350354a0350350
a036036ca0360368a0360364a0360360
a037037ca0370378a0370374a0370370
a038038ca0380388a0380384a0380380
a039039ca0390398a0390394a0390390
a03a03aca03a03a8a03a03a4a03a03a0
a03b03bca03b03b8a03b03b4a03b03b0
a03c03cca03c03c8a03c03c4a03c03c0
a03d03dca03d03d8a03d03d4a03d03d0
a03e03eca03e03e8a03e03e4a03e03e0
a03f03fca03f03f8a03f03f4a03f03f0
a040040ca0400408a0400404a0400400
a041041ca0410418a0410414a0410410
a042042ca0420428a0420424a0420420
a043043ca0430438a0430434a0430430
a044044ca0440448a0440444a0440440
a045045ca0450458a0450454a0450450
a046046ca0460468a0460464a0460460
a047047ca0470478a0470474a0470470
a048048ca0480488a0480484a0480480
a049049ca0490498a0490494a0490490
a04a04aca04a04a8a04a04a4a04a04a0
a04b04bca04b04b8a04b04b4a04b04b0
a04c04cca04c04c8a04c04c4a04c04c0
a04d04dca04d04d8a04d04d4a04d04d0
a04e04eca04e04e8a04e04e4a04e04e0
a04f04fca04f04f8a04f04f4a04f04f0
a050050ca0500508a0500504a0500500
a051051ca0510518a0510514a0510510
a052052ca0520528a0520524a0520520
a053053ca0530538a0530534a0530530
a054054ca0540548a0540544a0540540
a055055ca0550558a0550554a0550550
a056056ca0560568a0560564a0560560
a057057ca0570578a0570574a0570570
a058058ca0580588a0580584a0580580
a059059ca0590598a0590594a0590590
a05a05aca05a05a8a05a05a4a05a05a0
a05b05bca05b05b8a05b05b4a05b05b0
a05c05cca05c05c8a05c05c4a05c05c0
a05d05dca05d05d8a05d05d4a05d05d0
a05e05eca05e05e8a05e05e4a05e05e0
a05f05fca05f05f8a05f05f4a05f05f0
a060060ca0600608a0600604a0600600
a061061ca0610618a0610614a0610610
a062062ca0620628a0620624a0620620
a063063ca0630638a0630634a0630630
a064064ca0640648a0640644a0640640
a065065ca0650658a0650654a0650650
a066066ca0660668a0660664a0660660
a067067ca0670678a0670674a0670670
a068068ca0680688a0680684a0680680
a069069ca0690698a0690694a0690690
a06a06aca06a06a8a06a06a4a06a06a0
a06b06bca06b06b8a06b06b4a06b06b0
a06c06cca06c06c8a06c06c4a06c06c0
a06d06dca06d06d8a06d06d4a06d06d0
a06e06eca06e06e8a06e06e4a06e06e0
a06f06fca06f06f8a06f06f4a06f06f0
a070070ca0700708a0700704a0700700
a071071ca0710718a0710714a0710710
a072072ca0720728a0720724a0720720
a073073ca0730738a0730734a0730730
a074074ca0740748a0740744a0740740
a075075ca0750758a0750754a0750750
a076076ca0760768a0760764a0760760
a077077ca0770778a0770774a0770770
a078078ca0780788a0780784a0780780
a079079ca0790798a0790794a0790790
a07a07aca07a07a8a07a07a4a07a07a0
a07b07bca07b07b8a07b07b4a07b07b0
a07c07cca07c07c8a07c07c4a07c07c0
a07d07dca07d07d8a07d07d4a07d07d0
a07e07eca07e07e8a07e07e4a07e07e0
a07f07fca07f07f8a07f07f4a07f07f0

// File: project.f
icache_pkg.sv
fetch_pc_gen.sv
icache_way_sram.sv
line_fill_mem.sv
icache_core.sv
fetch_hold_reg.sv
icache_fetch_top.sv
tb_icache_asserts.sv
tb_icache_fetch.sv

// File: Bender.yml
package:
  name: icache_fetch

sources:
  - icache_pkg.sv
  - fetch_pc_gen.sv
  - icache_way_sram.sv
  - line_fill_mem.sv
  - icache_core.sv
  - fetch_hold_reg.sv
  - icache_fetch_top.sv
  - target: test
    files:
      - tb_icache_asserts.sv
      - tb_icache_fetch.sv

// File: tb_icache_fetch.sv
module tb_icache_fetch
	import icache_pkg::*;
();

	localparam int RESET_CYCLES   = 4;
	localparam int STRAIGHT_WORDS = 9;  // first cycle out of reset fetches nothing
	localparam int LOOP_PASSES    = 3;
	localparam int LOOP_WORDS     = 8;
	localparam int SET3_VISITS    = 7;
	localparam int VISIT_WORDS    = 4;  // stays inside one line
	localparam int DRAIN_CYCLES   = 4;
	localparam int MAX_BURST      = 3;

	localparam int SCENARIO_CYCLES = RESET_CYCLES + STRAIGHT_WORDS
		+ LOOP_PASSES * (1 + LOOP_WORDS) + SET3_VISITS * (1 + VISIT_WORDS) + DRAIN_CYCLES;
	localparam int STALL_BUDGET = MAX_BURST
		* (STRAIGHT_WORDS + LOOP_PASSES * LOOP_WORDS + SET3_VISITS * VISIT_WORDS);
	localparam int TIMEOUT_CYCLES = 2 * (SCENARIO_CYCLES + STALL_BUDGET);

	logic  clk;
	logic  rst;
	logic  stall;
	logic  redirect;
	addr_t redirect_pc;
	inst_t inst;
	addr_t inst_pc;
	logic  inst_valid;
	logic  miss;

	int cycle_count;
	int errors;

	// five tags in set 3 and then the two oldest again
	addr_t set3_pcs [SET3_VISITS] = '{11'h030, 11'h130, 11'h230, 11'h330, 11'h430,
		11'h030, 11'h130};

	icache_fetch_top dut0 (
		.clk         (clk),
		.rst         (rst),
		.stall       (stall),
		.redirect    (redirect),
		.redirect_pc (redirect_pc),
		.inst        (inst),
		.inst_pc     (inst_pc),
		.inst_valid  (inst_valid),
		.miss        (miss)
	);

	bind icache_fetch_top tb_icache_asserts asserts0 (
		.clk         (clk),
		.rst         (rst),
		.stall       (stall),
		.redirect    (redirect),
		.redirect_pc (redirect_pc),
		.inst        (inst),
		.inst_pc     (inst_pc),
		.inst_valid  (inst_valid),
		.miss        (miss)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// ==========================================================================
	// stimulus helpers
	// ==========================================================================

	// n unstalled cycles with random stall bursts in between
	task automatic fetch_words(input int n);
		int left;
		int burst;
		left = n;
		while (left > 0) begin
			if (($urandom % 4) == 0) begin
				burst = 1 + ($urandom % MAX_BURST);
				stall = 1'b1;
				repeat (burst) @(negedge clk);
				stall = 1'b0;
			end
			@(negedge clk);
			left--;
		end
	endtask

	// one-cycle redirect pulse with stall low
	task automatic jump_to(input addr_t target);
		redirect    = 1'b1;
		redirect_pc = target;
		@(negedge clk);
		redirect    = 1'b0;
	endtask

	// ==========================================================================
	// main sequence
	// ==========================================================================

	initial begin
		void'($urandom(32'h8110_5fae));
		cycle_count = 0;
		rst         = 1'b1;
		stall       = 1'b0;
		redirect    = 1'b0;
		redirect_pc = '0;

		repeat (RESET_CYCLES) @(negedge clk);
		rst = 1'b0;

		fetch_words(STRAIGHT_WORDS); // lines 0 and 1

		repeat (LOOP_PASSES) begin
			jump_to(RESET_PC);
			fetch_words(LOOP_WORDS);
		end

		foreach (set3_pcs[i]) begin
			jump_to(set3_pcs[i]);
			fetch_words(VISIT_WORDS);
		end

		repeat (DRAIN_CYCLES) @(negedge clk);

		errors = dut0.asserts0.fail_count;
		$display("assertion failures: %0d", errors);
		if (errors == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

	// watchdog
	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("timeout: tests still running after %0d cycles", cycle_count);
			$display("assertion failures: %0d", dut0.asserts0.fail_count);
			$display("Simulation failed");
			$finish;
		end
	end

endmodule

// File: tb_icache_asserts.sv
module tb_icache_asserts
	import icache_pkg::*;
(
	input logic  clk,
	input logic  rst,
	input logic  stall,
	input logic  redirect,
	input addr_t redirect_pc,
	input inst_t inst,
	input addr_t inst_pc,
	input logic  inst_valid,
	input logic  miss
);

	int fail_count;

	line_t ref_mem [MEM_LINES];
	line_t cur_line;
	inst_t exp_word;

	// reference tag store fed by delivered instructions
	tag_t   m_tag   [NUM_WAYS][NUM_SETS];
	logic   m_valid [NUM_WAYS][NUM_SETS];
	int     m_victim;
	logic   m_hit;
	logic   miss_q;   // miss of the lookup now at the output
	addr_t  exp_pc;
	logic   take;     // output consumed this cycle
	tag_t   pc_tag;
	index_t pc_set;

	initial begin
		fail_count = 0;
		$readmemh(MEM_FILE, ref_mem);
	end

	assign cur_line = ref_mem[inst_pc[10:4]];
	assign exp_word = cur_line[inst_pc[3:2]*32 +: 32];
	assign pc_tag   = inst_pc[10:8];
	assign pc_set   = inst_pc[7:4];
	assign take     = inst_valid && !stall;

	always_comb begin
		m_hit = 1'b0;
		for (int w = 0; w < NUM_WAYS; w++) begin
			if (m_valid[w][pc_set] && (m_tag[w][pc_set] == pc_tag)) begin
				m_hit = 1'b1;
			end
		end
	end

	// ==========================================================================
	// model update
	// ==========================================================================

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int w = 0; w < NUM_WAYS; w++) begin
				for (int s = 0; s < NUM_SETS; s++) begin
					m_valid[w][s] <= 1'b0;
				end
			end
			m_victim <= 0;
			miss_q   <= 1'b0;
			exp_pc   <= RESET_PC;
		end else begin
			if (!stall) begin
				miss_q <= miss;
			end
			if (take && !m_hit) begin
				m_valid[m_victim][pc_set] <= 1'b1;
				m_tag[m_victim][pc_set]   <= pc_tag;
				m_victim                  <= (m_victim + 1) % NUM_WAYS; // round robin
			end
			if (redirect && !stall) begin
				exp_pc <= redirect_pc;
			end else if (take) begin
				exp_pc <= exp_pc + addr_t'(4);
			end
		end
	end

	// ==========================================================================
	// properties
	// ==========================================================================

	a_word_matches_memory: assert property (@(posedge clk) disable iff (rst)
		inst_valid |-> inst == exp_word)
	else begin
		$error("error at %0t: inst %h at pc %h, memory holds %h",
			$time, $sampled(inst), $sampled(inst_pc), $sampled(exp_word));
		fail_count++;
	end

	a_quiet_after_reset: assert property (@(posedge clk) disable iff (rst)
		$fell(rst) |-> !inst_valid && !miss)
	else begin
		$error("error at %0t: inst_valid or miss high in the first cycle after reset",
			$time);
		fail_count++;
	end

	a_pc_sequence: assert property (@(posedge clk) disable iff (rst)
		take |-> inst_pc == exp_pc)
	else begin
		$error("error at %0t: inst_pc %h, expected %h",
			$time, $sampled(inst_pc), $sampled(exp_pc));
		fail_count++;
	end

	a_hold_under_stall: assert property (@(posedge clk) disable iff (rst)
		stall |=> $stable(inst) && $stable(inst_pc) && $stable(inst_valid))
	else begin
		$error("error at %0t: outputs changed while stall was high", $time);
		fail_count++;
	end

	a_redirect_bubble: assert property (@(posedge clk) disable iff (rst)
		redirect && !stall |=> !inst_valid)
	else begin
		$error("error at %0t: inst_valid high in the cycle after a redirect", $time);
		fail_count++;
	end

	a_miss_matches_model: assert property (@(posedge clk) disable iff (rst)
		!stall |-> miss_q == (inst_valid && !m_hit))
	else begin
		$error("error at %0t: miss was %b for pc %h, model expects %b",
			$time, $sampled(miss_q), $sampled(inst_pc),
			$sampled(inst_valid) && !$sampled(m_hit));
		fail_count++;
	end

endmodule

// File: icache_fetch_top.sv
module icache_fetch_top
	import icache_pkg::*;
(
	input  logic  clk,
	input  logic  rst,
	input  logic  stall,
	input  logic  redirect,
	input  addr_t redirect_pc,
	output inst_t inst,
	output addr_t inst_pc,
	output logic  inst_valid,
	output logic  miss
);

	// producer to cache
	addr_t fetch_addr;
	logic  fetch_valid;

	// cache to hold stage
	inst_t word;
	addr_t word_pc;
	logic  word_valid;

	// ==========================================================================
	// fetch address
	// ==========================================================================

	fetch_pc_gen pc_gen0 (
		.clk         (clk),
		.rst         (rst),
		.stall       (stall),
		.redirect    (redirect),
		.redirect_pc (redirect_pc),
		.fetch_addr  (fetch_addr),
		.fetch_valid (fetch_valid)
	);

	// ==========================================================================
	// cache
	// ==========================================================================

	icache_core cache0 (
		.clk         (clk),
		.rst         (rst),
		.stall       (stall),
		.fetch_addr  (fetch_addr),
		.fetch_valid (fetch_valid),
		.word        (word),
		.word_pc     (word_pc),
		.word_valid  (word_valid),
		.miss        (miss)
	);

	// ==========================================================================
	// hold stage
	// ==========================================================================

	fetch_hold_reg hold0 (
		.clk        (clk),
		.rst        (rst),
		.stall      (stall),
		.word       (word),
		.word_pc    (word_pc),
		.word_valid (word_valid),
		.inst       (inst),
		.inst_pc    (inst_pc),
		.inst_valid (inst_valid)
	);

endmodule

// File: fetch_hold_reg.sv
module fetch_hold_reg
	import icache_pkg::*;
(
	input  logic  clk,
	input  logic  rst,
	input  logic  stall,
	input  inst_t word,
	input  addr_t word_pc,
	input  logic  word_valid,
	output inst_t inst,
	output addr_t inst_pc,
	output logic  inst_valid
);

	logic  holding;
	inst_t inst_cap;
	addr_t pc_cap;
	logic  valid_cap;

	// set after the first stalled cycle, drops with stall
	always_ff @(posedge clk) begin
		if (rst) begin
			holding <= 1'b0;
		end else begin
			holding <= stall;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			valid_cap <= 1'b0;
		end else if (stall && !holding) begin
			valid_cap <= word_valid;
		end
	end

	// capture once, on entry to the stall
	always_ff @(posedge clk) begin
		if (stall && !holding) begin
			inst_cap <= word;
			pc_cap   <= word_pc;
		end
	end

	assign inst       = holding ? inst_cap  : word;
	assign inst_pc    = holding ? pc_cap    : word_pc;
	assign inst_valid = holding ? valid_cap : word_valid;

endmodule

// File: icache_core.sv
module icache_core
	import icache_pkg::*;
(
	input  logic  clk,
	input  logic  rst,
	input  logic  stall,
	input  addr_t fetch_addr,
	input  logic  fetch_valid,
	output inst_t word,
	output addr_t word_pc,
	output logic  word_valid,
	output logic  miss
);

	// tag store
	tag_t                tag_q   [NUM_WAYS][NUM_SETS];
	logic [NUM_SETS-1:0] valid_q [NUM_WAYS];

	// lookup cycle
	tag_t      tag;
	index_t    index;
	logic      lookup;
	way_mask_t hit;
	way_mask_t victim;    // one-hot, round-robin
	line_t     fill_line;

	// data arrays
	way_mask_t way_en;
	way_mask_t way_we;
	line_t     way_dout [NUM_WAYS];

	// response cycle
	way_mask_t hit_q;
	line_t     fill_q;
	addr_t     pc_q;
	line_t     line_sel;

	// ==========================================================================
	// lookup
	// ==========================================================================

	assign tag    = addr_tag(fetch_addr);
	assign index  = addr_index(fetch_addr);
	assign lookup = fetch_valid && !stall; // stalled cycles touch nothing

	always_comb begin
		for (int w = 0; w < NUM_WAYS; w++) begin
			hit[w] = valid_q[w][index] && (tag_q[w][index] == tag);
		end
	end

	assign miss = lookup && (hit == '0);

	// ==========================================================================
	// fill and replacement
	// ==========================================================================

	line_fill_mem fill_mem0 (
		.addr (fetch_addr),
		.line (fill_line)
	);

	// rotates once per fill
	always_ff @(posedge clk) begin
		if (rst) begin
			victim <= way_mask_t'(1);
		end else if (miss) begin
			victim <= {victim[NUM_WAYS-2:0], victim[NUM_WAYS-1]};
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int w = 0; w < NUM_WAYS; w++) begin
				valid_q[w] <= '0;
			end
		end else if (miss) begin
			for (int w = 0; w < NUM_WAYS; w++) begin
				if (victim[w]) begin
					valid_q[w][index] <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (miss) begin
			for (int w = 0; w < NUM_WAYS; w++) begin
				if (victim[w]) begin
					tag_q[w][index] <= tag;
				end
			end
		end
	end

	// hit way reads, victim way writes the fill line
	assign way_we = miss ? victim : '0;
	assign way_en = lookup ? (hit | way_we) : '0;

	for (genvar w = 0; w < NUM_WAYS; w++) begin : g_way
		icache_way_sram sram (
			.clk  (clk),
			.en   (way_en[w]),
			.we   (way_we[w]),
			.addr (index),
			.din  (fill_line),
			.dout (way_dout[w])
		);
	end

	// ==========================================================================
	// response
	// ==========================================================================

	always_ff @(posedge clk) begin
		if (rst) begin
			hit_q      <= '0;
			word_valid <= 1'b0;
		end else if (!stall) begin
			hit_q      <= fetch_valid ? hit : '0;
			word_valid <= fetch_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (!stall) begin
			fill_q <= fill_line; // used when the lookup missed
			pc_q   <= fetch_addr;
		end
	end

	always_comb begin
		line_sel = fill_q;
		for (int w = 0; w < NUM_WAYS; w++) begin
			if (hit_q[w]) begin
				line_sel = way_dout[w];
			end
		end
	end

	assign word    = line_word(line_sel, pc_q);
	assign word_pc = pc_q;

endmodule

// File: line_fill_mem.sv
module line_fill_mem
	import icache_pkg::*;
(
	input  addr_t addr,
	output line_t line
);

	line_t mem [MEM_LINES];
	logic [$clog2(MEM_LINES)-1:0] line_addr;

	// program image, one 128-bit line per row
	initial begin
		$readmemh(MEM_FILE, mem);
	end

	// line address is everything above the byte offset
	assign line_addr = addr[$bits(addr_t)-1 -: $clog2(MEM_LINES)];

	// whole line available in the lookup cycle
	assign line = mem[line_addr];

endmodule

// File: icache_way_sram.sv
module icache_way_sram
	import icache_pkg::*;
(
	input  logic   clk,
	input  logic   en,
	input  logic   we,
	input  index_t addr,
	input  line_t  din,
	output line_t  dout
);

	line_t mem [NUM_SETS];

	// single port, read data registered
	// on a write the old line comes out, the cache takes the fill line then
	always_ff @(posedge clk) begin
		if (en) begin
			if (we) begin
				mem[addr] <= din;
			end
			dout <= mem[addr];
		end
	end

	// dout keeps its last value while en is low

endmodule

// File: fetch_pc_gen.sv
module fetch_pc_gen
	import icache_pkg::*;
(
	input  logic  clk,
	input  logic  rst,
	input  logic  stall,
	input  logic  redirect,
	input  addr_t redirect_pc,
	output addr_t fetch_addr,
	output logic  fetch_valid
);

	addr_t pc;
	logic  started; // low for the first cycle out of reset

	always_ff @(posedge clk) begin
		if (rst) begin
			pc      <= RESET_PC;
			started <= 1'b0;
		end else begin
			started <= 1'b1;
			if (!stall) begin
				if (redirect) begin
					pc <= redirect_pc;     // new target, fetched next cycle
				end else if (started) begin
					pc <= pc + addr_t'(4); // one word per cycle
				end
			end
		end
	end

	// RESET_PC is not stepped past before it has been fetched once

	assign fetch_addr = pc;

	// redirect cancels the fetch already in flight
	assign fetch_valid = started && !redirect;

endmodule

// File: icache_pkg.sv
package icache_pkg;

	// ==========================================================================
	// address and data widths
	// ==========================================================================

	typedef logic [10:0]  addr_t;     // byte address into 2 KB of program
	typedef logic [2:0]   tag_t;      // addr 10:8
	typedef logic [3:0]   index_t;    // addr 7:4
	typedef logic [31:0]  inst_t;
	typedef logic [127:0] line_t;     // four words per line
	typedef logic [3:0]   way_mask_t; // hit mask or one-hot way

	// ==========================================================================
	// geometry
	// ==========================================================================

	localparam int NUM_WAYS  = 4;
	localparam int NUM_SETS  = 16;
	localparam int MEM_LINES = 128;

	localparam addr_t RESET_PC = '0;
	localparam MEM_FILE = "program.hex";

	// address fields and word select
	function automatic tag_t addr_tag(input addr_t a);
		return a[10:8];
	endfunction

	function automatic index_t addr_index(input addr_t a);
		return a[7:4];
	endfunction

	// word at byte offset 3:2 within a line
	function automatic inst_t line_word(input line_t l, input addr_t a);
		return l[{a[3:2], 5'b0} +: $bits(inst_t)];
	endfunction

endpackage
